//--- verilog/rv32i_pkg.sv
package rv32i_pkg;

	typedef logic [31:0] rv32i_word;
	typedef logic [4:0] rv32i_reg;

	localparam rv32i_word RESET_PC = 32'h0000_0000;
	localparam int NUM_REGS = 32;

	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011
	} rv32i_opcode;

	typedef enum logic [2:0] {
		beq  = 3'b000,
		bne  = 3'b001,
		blt  = 3'b100,
		bge  = 3'b101,
		bltu = 3'b110,
		bgeu = 3'b111
	} branch_funct3_t;

	typedef enum logic [2:0] {
		lb  = 3'b000,
		lh  = 3'b001,
		lw  = 3'b010,
		lbu = 3'b100,
		lhu = 3'b101
	} load_funct3_t;

	typedef enum logic [2:0] {sb = 3'b000, sh = 3'b001, sw = 3'b010} store_funct3_t;

	typedef enum logic [2:0] {add, sll, slt, sltu, axor, sr, aor, aand} arith_funct3_t;

	typedef enum logic [2:0] {
		alu_add, alu_sll, alu_sra, alu_sub, alu_xor, alu_srl, alu_or, alu_and
	} alu_ops;

	typedef enum logic {am1_rs1, am1_pc} alumux1_sel_t;
	typedef enum logic [2:0] {
		am2_i_imm, am2_u_imm, am2_b_imm, am2_s_imm, am2_j_imm, am2_rs2
	} alumux2_sel_t;
	typedef enum logic {cm_rs2, cm_i_imm} cmpmux_sel_t;
	typedef enum logic [2:0] {
		rfm_alu_out, rfm_br_en, rfm_u_imm, rfm_pc_plus4, rfm_mem_rdata
	} regfilemux_sel_t;

	typedef struct packed {
		alumux1_sel_t alumux1_sel;
		alumux2_sel_t alumux2_sel;
		cmpmux_sel_t cmpmux_sel;
		regfilemux_sel_t regfilemux_sel;
		alu_ops aluop;
		branch_funct3_t cmpop;
		logic load_regfile;
		logic mem_read;
		logic mem_write;
		logic is_branch;
		logic is_jump;
		logic [2:0] funct3;
		rv32i_reg src1;
		rv32i_reg src2;
		rv32i_reg dest;
		rv32i_word i_imm;
		rv32i_word s_imm;
		rv32i_word b_imm;
		rv32i_word u_imm;
		rv32i_word j_imm;
	} control_word_t;

	// one view per instruction format
	typedef struct packed {
		logic [6:0] funct7;
		rv32i_reg rs2;
		rv32i_reg rs1;
		logic [2:0] funct3;
		rv32i_reg rd;
		rv32i_opcode opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm11_0;
		rv32i_reg rs1;
		logic [2:0] funct3;
		rv32i_reg rd;
		rv32i_opcode opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm11_5;
		rv32i_reg rs2;
		rv32i_reg rs1;
		logic [2:0] funct3;
		logic [4:0] imm4_0;
		rv32i_opcode opcode;
	} s_fmt_t;

	typedef struct packed {
		logic imm12;
		logic [5:0] imm10_5;
		rv32i_reg rs2;
		rv32i_reg rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic imm11;
		rv32i_opcode opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm31_12;
		rv32i_reg rd;
		rv32i_opcode opcode;
	} u_fmt_t;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10_1;
		logic imm11;
		logic [7:0] imm19_12;
		rv32i_reg rd;
		rv32i_opcode opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} inst_u;

endpackage

//--- verilog/lsu_if.sv
`timescale 1ns/1ns

interface lsu_if;
	import rv32i_pkg::*;

	logic req;
	logic write;
	logic [2:0] funct3; // load or store width
	rv32i_word addr;
	rv32i_word wdata;
	rv32i_word rdata; // already extended
	logic done;

	modport core (
		output req, write, funct3, addr, wdata,
		input rdata, done
	);

	modport lsu (
		input req, write, funct3, addr, wdata,
		output rdata, done
	);

endinterface

//--- verilog/control.sv
`timescale 1ns/1ns

module control (
	input rv32i_pkg::rv32i_word i_inst,
	output rv32i_pkg::control_word_t o_cw
);
	import rv32i_pkg::*;

	inst_u inst;
	control_word_t cw;
	alumux2_sel_t op2_sel;
	cmpmux_sel_t cmp_sel;

	function automatic control_word_t load_rf(control_word_t c, regfilemux_sel_t sel);
		c.load_regfile = 1'b1;
		c.regfilemux_sel = sel;
		return c;
	endfunction

	function automatic control_word_t set_alu(control_word_t c, alumux1_sel_t sel1,
						alumux2_sel_t sel2, alu_ops op = alu_add);
		c.alumux1_sel = sel1;
		c.alumux2_sel = sel2;
		c.aluop = op;
		return c;
	endfunction

	function automatic control_word_t set_cmp(control_word_t c, cmpmux_sel_t sel,
						branch_funct3_t op);
		c.cmpmux_sel = sel;
		c.cmpop = op;
		return c;
	endfunction

	assign inst = i_inst;
	assign o_cw = cw;

	always_comb begin
		cw = '0;
		cw.funct3 = inst.r.funct3;
		cw.src1 = inst.r.rs1;
		cw.src2 = inst.r.rs2;
		cw.dest = inst.r.rd;
		cw.i_imm = {{20{inst.i.imm11_0[11]}}, inst.i.imm11_0};
		cw.s_imm = {{20{inst.s.imm11_5[6]}}, inst.s.imm11_5, inst.s.imm4_0};
		cw.b_imm = {{20{inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5, inst.b.imm4_1, 1'b0};
		cw.u_imm = {inst.u.imm31_12, 12'h000};
		cw.j_imm = {{12{inst.j.imm20}}, inst.j.imm19_12, inst.j.imm11, inst.j.imm10_1, 1'b0};

		if (inst.r.opcode == op_reg) begin // second operand for arith
			op2_sel = am2_rs2;
			cmp_sel = cm_rs2;
		end else begin
			op2_sel = am2_i_imm;
			cmp_sel = cm_i_imm;
		end

		case (inst.r.opcode)
			op_lui: cw = load_rf(cw, rfm_u_imm);
			op_auipc: begin
				cw = load_rf(cw, rfm_alu_out);
				cw = set_alu(cw, am1_pc, am2_u_imm);
			end
			op_jal: begin
				cw = load_rf(cw, rfm_pc_plus4);
				cw = set_alu(cw, am1_pc, am2_j_imm);
				cw.is_jump = 1'b1;
			end
			op_jalr: begin
				cw = load_rf(cw, rfm_pc_plus4);
				cw = set_alu(cw, am1_rs1, am2_i_imm);
				cw.is_jump = 1'b1;
			end
			op_br: begin
				cw = set_alu(cw, am1_pc, am2_b_imm); // branch target
				cw = set_cmp(cw, cm_rs2, branch_funct3_t'(inst.b.funct3));
				cw.is_branch = 1'b1;
			end
			op_load: begin
				cw = load_rf(cw, rfm_mem_rdata);
				cw = set_alu(cw, am1_rs1, am2_i_imm);
				cw.mem_read = 1'b1;
			end
			op_store: begin
				cw = set_alu(cw, am1_rs1, am2_s_imm);
				cw.mem_write = 1'b1;
			end
			op_imm, op_reg: begin
				cw = load_rf(cw, rfm_alu_out);
				case (arith_funct3_t'(inst.r.funct3))
					add: begin
						if (inst.r.opcode == op_reg && inst.r.funct7[5])
							cw = set_alu(cw, am1_rs1, op2_sel, alu_sub);
						else
							cw = set_alu(cw, am1_rs1, op2_sel, alu_add);
					end
					sll: cw = set_alu(cw, am1_rs1, op2_sel, alu_sll);
					slt: begin
						cw = load_rf(cw, rfm_br_en);
						cw = set_cmp(cw, cmp_sel, blt);
					end
					sltu: begin
						cw = load_rf(cw, rfm_br_en);
						cw = set_cmp(cw, cmp_sel, bltu);
					end
					axor: cw = set_alu(cw, am1_rs1, op2_sel, alu_xor);
					sr: begin
						if (inst.r.funct7[5]) // srai shares this bit
							cw = set_alu(cw, am1_rs1, op2_sel, alu_sra);
						else
							cw = set_alu(cw, am1_rs1, op2_sel, alu_srl);
					end
					aor: cw = set_alu(cw, am1_rs1, op2_sel, alu_or);
					aand: cw = set_alu(cw, am1_rs1, op2_sel, alu_and);
					default: ;
				endcase
			end
			default: ; // unknown opcode retires as a no-op
		endcase
	end

endmodule

//--- verilog/regfile.sv
`timescale 1ns/1ns

module regfile (
	input logic clk,
	input logic i_rst_n,
	input logic i_we,
	input rv32i_pkg::rv32i_reg i_rs1,
	input rv32i_pkg::rv32i_reg i_rs2,
	input rv32i_pkg::rv32i_reg i_rd,
	input rv32i_pkg::rv32i_word i_wdata,
	output rv32i_pkg::rv32i_word o_rs1_data,
	output rv32i_pkg::rv32i_word o_rs2_data
);
	import rv32i_pkg::*;

	rv32i_word regs [NUM_REGS];

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_we && i_rd != '0) begin // x0 stays zero
			regs[i_rd] <= i_wdata;
		end
	end

	assign o_rs1_data = regs[i_rs1];
	assign o_rs2_data = regs[i_rs2];

endmodule

//--- verilog/exec_unit.sv
`timescale 1ns/1ns

module exec_unit (
	input rv32i_pkg::control_word_t i_cw,
	input rv32i_pkg::rv32i_word i_pc,
	input rv32i_pkg::rv32i_word i_rs1_data,
	input rv32i_pkg::rv32i_word i_rs2_data,
	output rv32i_pkg::rv32i_word o_alu_out,
	output logic o_br_en
);
	import rv32i_pkg::*;

	rv32i_word alu_a;
	rv32i_word alu_b;
	rv32i_word cmp_b;

	assign alu_a = (i_cw.alumux1_sel == am1_pc) ? i_pc : i_rs1_data;
	assign cmp_b = (i_cw.cmpmux_sel == cm_i_imm) ? i_cw.i_imm : i_rs2_data;

	always_comb begin
		case (i_cw.alumux2_sel)
			am2_u_imm: alu_b = i_cw.u_imm;
			am2_b_imm: alu_b = i_cw.b_imm;
			am2_s_imm: alu_b = i_cw.s_imm;
			am2_j_imm: alu_b = i_cw.j_imm;
			am2_rs2: alu_b = i_rs2_data;
			default: alu_b = i_cw.i_imm;
		endcase
	end

	always_comb begin
		case (i_cw.aluop)
			alu_add: o_alu_out = alu_a + alu_b;
			alu_sll: o_alu_out = alu_a << alu_b[4:0];
			alu_sra: o_alu_out = $unsigned($signed(alu_a) >>> alu_b[4:0]);
			alu_sub: o_alu_out = alu_a - alu_b;
			alu_xor: o_alu_out = alu_a ^ alu_b;
			alu_srl: o_alu_out = alu_a >> alu_b[4:0];
			alu_or: o_alu_out = alu_a | alu_b;
			default: o_alu_out = alu_a & alu_b;
		endcase
	end

	always_comb begin
		case (i_cw.cmpop)
			beq: o_br_en = (i_rs1_data == cmp_b);
			bne: o_br_en = (i_rs1_data != cmp_b);
			blt: o_br_en = ($signed(i_rs1_data) < $signed(cmp_b));
			bge: o_br_en = ($signed(i_rs1_data) >= $signed(cmp_b));
			bltu: o_br_en = (i_rs1_data < cmp_b);
			bgeu: o_br_en = (i_rs1_data >= cmp_b);
			default: o_br_en = 1'b0;
		endcase
	end

endmodule

//--- verilog/lsu_apb.sv
`timescale 1ns/1ns

module lsu_apb (
	input logic clk,
	input logic i_rst_n,
	lsu_if.lsu lsu,
	output rv32i_pkg::rv32i_word o_paddr,
	output logic o_psel,
	output logic o_penable,
	output logic o_pwrite,
	output rv32i_pkg::rv32i_word o_pwdata,
	output logic [3:0] o_pstrb,
	input rv32i_pkg::rv32i_word i_prdata,
	input logic i_pready
);
	import rv32i_pkg::*;

	typedef enum logic [1:0] {st_idle, st_setup, st_access} state_t;

	state_t state;
	state_t state_nxt;
	rv32i_word wdata_lanes;
	logic [3:0] strb_lanes;
	rv32i_word rdata_shift;
	logic start;

	assign start = (state == st_idle) && lsu.req;

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: if (lsu.req) state_nxt = st_setup;
			st_setup: state_nxt = st_access;
			st_access: if (i_pready) state_nxt = st_idle;
			default: state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= st_idle;
			o_pwrite <= 1'b0;
			o_pstrb <= 4'b0000;
		end else begin
			state <= state_nxt;
			if (start) begin
				o_pwrite <= lsu.write;
				o_pstrb <= lsu.write ? strb_lanes : 4'b0000; // no strobes on reads
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			o_paddr <= {lsu.addr[31:2], 2'b00};
			o_pwdata <= wdata_lanes;
		end
	end

	// replicate narrow store data on every lane
	always_comb begin
		case (store_funct3_t'(lsu.funct3))
			sb: begin
				wdata_lanes = {4{lsu.wdata[7:0]}};
				strb_lanes = 4'b0001 << lsu.addr[1:0];
			end
			sh: begin
				wdata_lanes = {2{lsu.wdata[15:0]}};
				strb_lanes = lsu.addr[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				wdata_lanes = lsu.wdata;
				strb_lanes = 4'b1111;
			end
		endcase
	end

	assign rdata_shift = i_prdata >> {lsu.addr[1:0], 3'b000};

	always_comb begin
		case (load_funct3_t'(lsu.funct3))
			lb: lsu.rdata = {{24{rdata_shift[7]}}, rdata_shift[7:0]};
			lh: lsu.rdata = {{16{rdata_shift[15]}}, rdata_shift[15:0]};
			lbu: lsu.rdata = {24'h000000, rdata_shift[7:0]};
			lhu: lsu.rdata = {16'h0000, rdata_shift[15:0]};
			default: lsu.rdata = i_prdata;
		endcase
	end

	assign lsu.done = (state == st_access) && i_pready;
	assign o_psel = (state != st_idle);
	assign o_penable = (state == st_access);

endmodule

//--- verilog/rv32i_datapath.sv
`timescale 1ns/1ns

module rv32i_datapath (
	input logic clk,
	input logic i_rst_n,
	input rv32i_pkg::control_word_t i_cw,
	output rv32i_pkg::rv32i_word o_imem_addr,
	input rv32i_pkg::rv32i_word i_imem_rdata,
	output rv32i_pkg::rv32i_word o_inst,
	lsu_if.core lsu
);
	import rv32i_pkg::*;

	rv32i_word pc;
	rv32i_word pc_plus4;
	rv32i_word next_pc;
	rv32i_word rs1_data;
	rv32i_word rs2_data;
	rv32i_word alu_out;
	rv32i_word rf_wdata;
	logic br_en;
	logic is_mem;
	logic retire;

	regfile regfile_i (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_we(i_cw.load_regfile && retire),
		.i_rs1(i_cw.src1),
		.i_rs2(i_cw.src2),
		.i_rd(i_cw.dest),
		.i_wdata(rf_wdata),
		.o_rs1_data(rs1_data),
		.o_rs2_data(rs2_data)
	);

	exec_unit exec_unit_i (
		.i_cw(i_cw),
		.i_pc(pc),
		.i_rs1_data(rs1_data),
		.i_rs2_data(rs2_data),
		.o_alu_out(alu_out),
		.o_br_en(br_en)
	);

	assign o_imem_addr = pc;
	assign o_inst = i_imem_rdata;
	assign pc_plus4 = pc + 32'd4;

	// memory ops hold here until the lsu reports done
	assign is_mem = i_cw.mem_read || i_cw.mem_write;
	assign retire = !is_mem || lsu.done;

	assign lsu.req = is_mem;
	assign lsu.write = i_cw.mem_write;
	assign lsu.funct3 = i_cw.funct3;
	assign lsu.addr = alu_out;
	assign lsu.wdata = rs2_data;

	always_comb begin
		if (i_cw.is_jump && i_cw.alumux1_sel == am1_pc)
			next_pc = alu_out; // jal
		else if (i_cw.is_jump)
			next_pc = {alu_out[31:1], 1'b0}; // jalr
		else if (i_cw.is_branch && br_en)
			next_pc = alu_out;
		else
			next_pc = pc_plus4;
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n)
			pc <= RESET_PC;
		else if (retire)
			pc <= next_pc;
	end

	always_comb begin
		case (i_cw.regfilemux_sel)
			rfm_br_en: rf_wdata = {31'b0, br_en}; // slt and sltu
			rfm_u_imm: rf_wdata = i_cw.u_imm;
			rfm_pc_plus4: rf_wdata = pc_plus4;
			rfm_mem_rdata: rf_wdata = lsu.rdata;
			default: rf_wdata = alu_out;
		endcase
	end

endmodule

//--- verilog/rv32i_top.sv
`timescale 1ns/1ns

module rv32i_top (
	input logic clk,
	input logic i_rst_n,
	output rv32i_pkg::rv32i_word o_imem_addr,
	input rv32i_pkg::rv32i_word i_imem_rdata,
	output rv32i_pkg::rv32i_word o_paddr,
	output logic o_psel,
	output logic o_penable,
	output logic o_pwrite,
	output rv32i_pkg::rv32i_word o_pwdata,
	output logic [3:0] o_pstrb,
	input rv32i_pkg::rv32i_word i_prdata,
	input logic i_pready
);
	import rv32i_pkg::*;

	control_word_t cw;
	rv32i_word inst;

	lsu_if lsu_bus ();

	control control_i (
		.i_inst(inst),
		.o_cw(cw)
	);

	rv32i_datapath rv32i_datapath_i (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_cw(cw),
		.o_imem_addr(o_imem_addr),
		.i_imem_rdata(i_imem_rdata),
		.o_inst(inst),
		.lsu(lsu_bus.core)
	);

	lsu_apb lsu_apb_i (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.lsu(lsu_bus.lsu),
		.o_paddr(o_paddr),
		.o_psel(o_psel),
		.o_penable(o_penable),
		.o_pwrite(o_pwrite),
		.o_pwdata(o_pwdata),
		.o_pstrb(o_pstrb),
		.i_prdata(i_prdata),
		.i_pready(i_pready)
	);

endmodule

//--- dv/rv32i_apb_chk.sv
`timescale 1ns/1ns

module rv32i_apb_chk (
	input logic clk,
	input logic i_rst_n,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pwrite,
	input logic [31:0] paddr,
	input logic [31:0] pwdata,
	input logic [3:0] pstrb,
	input logic req,
	input logic done,
	input logic [31:0] req_addr,
	input logic req_write
);

	int fail_count = 0;

	a_enable_after_setup: assert property (@(posedge clk) disable iff (!i_rst_n)
		$rose(penable) |-> $past(psel))
		else begin
			$error("penable rose without a setup cycle");
			fail_count++;
		end

	a_fields_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
		psel && !pready |=> $stable(paddr) && $stable(pwrite) && $stable(pwdata) && $stable(pstrb))
		else begin
			$error("apb fields changed during a transfer");
			fail_count++;
		end

	a_sel_held: assert property (@(posedge clk) disable iff (!i_rst_n)
		psel && !(penable && pready) |=> psel)
		else begin
			$error("psel dropped before pready");
			fail_count++;
		end

	// request held by the stalled core
	a_req_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
		req && !done |=> req && $stable(req_addr) && $stable(req_write))
		else begin
			$error("core request changed while stalled");
			fail_count++;
		end

endmodule

bind lsu_apb rv32i_apb_chk apb_chk_i (
	.clk(clk),
	.i_rst_n(i_rst_n),
	.psel(o_psel),
	.penable(o_penable),
	.pready(i_pready),
	.pwrite(o_pwrite),
	.paddr(o_paddr),
	.pwdata(o_pwdata),
	.pstrb(o_pstrb),
	.req(lsu.req),
	.done(lsu.done),
	.req_addr(lsu.addr),
	.req_write(lsu.write)
);

//--- dv/rv32i_tb.sv
`timescale 1ns/1ns

module rv32i_tb;
	import rv32i_pkg::*;

	localparam int TIMEOUT_CYCLES = 2000; // 6 tests x 40 instr x 6 cycles rounded up

	logic clk;
	logic i_rst_n;
	rv32i_word o_imem_addr;
	rv32i_word i_imem_rdata;
	rv32i_word o_paddr;
	logic o_psel;
	logic o_penable;
	logic o_pwrite;
	rv32i_word o_pwdata;
	logic [3:0] o_pstrb;
	rv32i_word i_prdata;
	logic i_pready;

	rv32i_word imem [128];
	rv32i_word mem [256];
	rv32i_word prog [$];
	rv32i_word exp_addr [$];
	rv32i_word exp_data [$];
	logic [3:0] exp_strb [$];
	rv32i_word got_addr [$];
	rv32i_word got_data [$];
	logic [3:0] got_strb [$];
	int seed = 32'h8c93_9c49;
	int cycles = 0;
	int waits = 0;
	int slot = 0;
	bit use_waits = 1'b0;

	rv32i_top rv32i_top_i (.*);

	assign i_imem_rdata = imem[o_imem_addr[8:2]];

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the core did not reach the end of the program");
			$display("tests failed");
			$fatal(1);
		end
	end

	// bound assertions count their failures
	always @(negedge clk) begin
		if (rv32i_top_i.lsu_apb_i.apb_chk_i.fail_count != 0)
			fail_now("an APB protocol or stall assertion failed");
	end

	// APB slave answering on the falling edge
	always @(negedge clk) begin
		i_pready = 1'b0;
		if (o_psel && !o_penable) begin
			waits = use_waits ? $unsigned($random(seed)) % 4 : 0;
		end else if (o_psel && o_penable) begin
			if (waits != 0) begin
				waits--;
			end else begin
				i_pready = 1'b1;
				i_prdata = mem[o_paddr[9:2]];
				if (o_pwrite) begin
					for (int b = 0; b < 4; b++)
						if (o_pstrb[b]) mem[o_paddr[9:2]][8*b +: 8] = o_pwdata[8*b +: 8];
					got_addr.push_back(o_paddr);
					got_data.push_back(o_pwdata);
					got_strb.push_back(o_pstrb);
				end
			end
		end
	end

	function automatic rv32i_word fill(int idx);
		return idx * 32'h9e37_79b9 + 32'h8070_ff01;
	endfunction

	function automatic rv32i_word lane_mask(logic [3:0] s);
		return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
	endfunction

	function automatic rv32i_word enc_r(logic [6:0] f7, rv32i_reg rs2, rv32i_reg rs1,
						logic [2:0] f3, rv32i_reg rd, logic [6:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic rv32i_word enc_i(logic [11:0] imm, rv32i_reg rs1, logic [2:0] f3,
						rv32i_reg rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic rv32i_word enc_s(logic [11:0] imm, rv32i_reg rs2, rv32i_reg rs1,
						logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic rv32i_word enc_b(logic [12:0] imm, rv32i_reg rs2, rv32i_reg rs1,
						logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic rv32i_word enc_j(logic [20:0] imm, rv32i_reg rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// ISA reference for op_imm and op_reg results
	function automatic rv32i_word isa_ref(logic [2:0] f3, logic alt, rv32i_word a, rv32i_word b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic rv32i_word br_ref(logic [2:0] f3, rv32i_word a, rv32i_word b);
		case (f3)
			3'd0: return {31'b0, a == b};
			3'd1: return {31'b0, a != b};
			3'd4: return {31'b0, $signed(a) < $signed(b)};
			3'd5: return {31'b0, $signed(a) >= $signed(b)};
			3'd6: return {31'b0, a < b};
			default: return {31'b0, a >= b};
		endcase
	endfunction

	function automatic rv32i_word load_ref(logic [2:0] f3, rv32i_word w, int off);
		rv32i_word s;
		s = w >> (8 * off);
		case (f3)
			3'd0: return {{24{s[7]}}, s[7:0]};
			3'd1: return {{16{s[15]}}, s[15:0]};
			3'd4: return {24'h0, s[7:0]};
			default: return {16'h0, s[15:0]};
		endcase
	endfunction

	task automatic fail_now(string what);
		$display("%s", what);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_word(string name, rv32i_word got, rv32i_word exp);
		if (got !== exp) begin
			fail_now($sformatf("error %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_strb(string name, logic [3:0] got, logic [3:0] exp);
		if (got !== exp) begin
			fail_now($sformatf("error %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			fail_now($sformatf("error %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic emit(rv32i_word w);
		prog.push_back(w);
	endtask

	task automatic expect_store(rv32i_word addr, rv32i_word data, logic [3:0] strb);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
		exp_strb.push_back(strb);
	endtask

	task automatic emit_sw(rv32i_reg rs, rv32i_word exp);
		rv32i_word addr;
		addr = 32'h100 + 4 * slot;
		emit(enc_s(addr[11:0], rs, 5'd0, 3'b010));
		expect_store(addr, exp, 4'hf);
		slot++;
	endtask

	task automatic emit_li(rv32i_reg rd, rv32i_word v);
		rv32i_word hi;
		hi = v + 32'h800; // addi sign-extends the low part
		emit({hi[31:12], rd, op_lui});
		emit(enc_i(v[11:0], rd, 3'b000, rd, op_imm));
	endtask

	task automatic start_prog();
		prog.delete();
		exp_addr.delete();
		exp_data.delete();
		exp_strb.delete();
		slot = 0;
	endtask

	task automatic check_stores();
		if (got_addr.size() != exp_addr.size())
			fail_now($sformatf("wrong number of stores: saw %0d, wanted %0d",
				got_addr.size(), exp_addr.size()));
		foreach (exp_addr[i]) begin
			check_word("o_paddr", got_addr[i], exp_addr[i]);
			check_strb("o_pstrb", got_strb[i], exp_strb[i]);
			check_word("o_pwdata", got_data[i] & lane_mask(exp_strb[i]),
				exp_data[i] & lane_mask(exp_strb[i]));
		end
	endtask

	task automatic run_prog();
		rv32i_word end_pc;
		i_rst_n = 1'b0;
		end_pc = RESET_PC + prog.size() * 4;
		emit(enc_j(21'd0, 5'd0)); // park here
		for (int i = 0; i < 128; i++) imem[i] = 32'h0000_0013;
		foreach (prog[i]) imem[i] = prog[i];
		for (int i = 0; i < 256; i++) mem[i] = fill(i);
		got_addr.delete();
		got_data.delete();
		got_strb.delete();
		repeat (16) @(negedge clk);
		i_rst_n = 1'b1;
		while (o_imem_addr != end_pc) @(negedge clk);
		check_stores();
	endtask

	task automatic test_reset();
		start_prog();
		i_rst_n = 1'b0;
		repeat (16) @(negedge clk);
		i_rst_n = 1'b1;
		check_bit("o_psel", o_psel, 1'b0);
		check_bit("o_penable", o_penable, 1'b0);
		check_bit("o_pwrite", o_pwrite, 1'b0);
		check_strb("o_pstrb", o_pstrb, 4'h0);
		check_word("o_imem_addr", o_imem_addr, RESET_PC);
	endtask

	task automatic build_arith();
		rv32i_word a;
		rv32i_word b;
		logic [11:0] imm;
		a = 32'hffff_f9c3;
		b = 32'h0000_1234;
		emit_li(5'd1, a);
		emit_li(5'd2, b);
		for (int f3 = 0; f3 < 8; f3++) begin
			for (int alt = 0; alt < 2; alt++) begin
				if (alt == 1 && f3 != 0 && f3 != 5) continue;
				emit(enc_r({1'b0, alt[0], 5'b0}, 5'd2, 5'd1, f3[2:0], 5'd5, op_reg));
				emit_sw(5'd5, isa_ref(f3[2:0], alt[0], a, b));
				if (f3 == 0 && alt == 1) continue; // there is no subi
				imm = (f3 == 1 || f3 == 5) ? {1'b0, alt[0], 10'd5} : 12'hff9;
				emit(enc_i(imm, 5'd1, f3[2:0], 5'd6, op_imm));
				emit_sw(5'd6, isa_ref(f3[2:0], alt[0], a, {{20{imm[11]}}, imm}));
			end
		end
	endtask

	task automatic test_arith();
		start_prog();
		build_arith();
		run_prog();
	endtask

	task automatic test_jumps();
		rv32i_word pc_now;
		rv32i_word tgt;
		rv32i_word skip;
		start_prog();
		skip = enc_s(12'h1fc, 5'd0, 5'd0, 3'b010);
		emit({20'habcde, 5'd5, op_lui});
		emit_sw(5'd5, 32'habcd_e000);
		pc_now = RESET_PC + prog.size() * 4;
		emit({20'h00012, 5'd6, op_auipc});
		emit_sw(5'd6, pc_now + 32'h12000);
		pc_now = RESET_PC + prog.size() * 4;
		emit(enc_j(21'd8, 5'd7));
		emit(skip);
		emit_sw(5'd7, pc_now + 4);
		tgt = RESET_PC + (prog.size() + 4) * 4;
		emit_li(5'd8, tgt + 1); // bit 0 must be dropped
		pc_now = RESET_PC + prog.size() * 4;
		emit(enc_i(12'h000, 5'd8, 3'b000, 5'd9, op_jalr));
		emit(skip);
		emit_sw(5'd9, pc_now + 4);
		run_prog();
	endtask

	task automatic test_branches();
		logic [2:0] brs [6];
		rv32i_word vals [3];
		rv32i_reg ra;
		rv32i_reg rb;
		brs = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		vals = '{32'h0, 32'hffff_fffb, 32'h3};
		start_prog();
		emit_li(5'd1, vals[1]);
		emit_li(5'd2, vals[2]);
		foreach (brs[i]) begin
			for (int p = 0; p < 3; p++) begin
				ra = (p == 1) ? 5'd2 : 5'd1;
				rb = (p == 0) ? 5'd2 : 5'd1;
				emit(enc_b(13'd12, rb, ra, brs[i]));
				emit(enc_i(12'd0, 5'd0, 3'b000, 5'd10, op_imm));
				emit(enc_j(21'd8, 5'd0));
				emit(enc_i(12'd1, 5'd0, 3'b000, 5'd10, op_imm));
				emit_sw(5'd10, br_ref(brs[i], vals[ra], vals[rb]));
			end
		end
		run_prog();
	endtask

	task automatic test_loads();
		start_prog();
		emit_li(5'd1, 32'h1122_33c4);
		for (int k = 0; k < 4; k++) begin
			emit(enc_s(12'h140 + k, 5'd1, 5'd0, 3'b000));
			expect_store(32'h140, {4{8'hc4}}, 4'b0001 << k);
		end
		for (int k = 0; k < 4; k += 2) begin
			emit(enc_s(12'h150 + k, 5'd1, 5'd0, 3'b001));
			expect_store(32'h150, {2{16'h33c4}}, (k == 2) ? 4'b1100 : 4'b0011);
		end
		for (int f3 = 0; f3 < 6; f3++) begin
			if (f3 == 2 || f3 == 3) continue;
			for (int off = 0; off < 4; off += ((f3 % 4) == 1) ? 2 : 1) begin
				emit(enc_i(12'h014 + off, 5'd0, f3[2:0], 5'd5, op_load)); // word 5 has both signs
				emit_sw(5'd5, load_ref(f3[2:0], fill(5), off));
			end
		end
		run_prog();
	endtask

	task automatic test_backpressure();
		use_waits = 1'b1;
		test_arith();
		use_waits = 1'b0;
	endtask

	initial begin
		i_rst_n = 1'b0;
		i_prdata = '0;
		i_pready = 1'b0;
		@(negedge clk);
		test_reset();
		test_arith();
		test_jumps();
		test_branches();
		test_loads();
		test_backpressure();
		if (rv32i_top_i.lsu_apb_i.apb_chk_i.fail_count != 0) begin
			fail_now("an APB protocol or stall assertion failed");
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

//--- compile.f
verilog/rv32i_pkg.sv
verilog/lsu_if.sv
verilog/control.sv
verilog/regfile.sv
verilog/exec_unit.sv
verilog/lsu_apb.sv
verilog/rv32i_datapath.sv
verilog/rv32i_top.sv
dv/rv32i_apb_chk.sv
dv/rv32i_tb.sv
